// ==== flist.f ====
hdl/bignum_pkg.sv
hdl/operand_bank.sv
hdl/bignum_multiplier.sv
hdl/display_readout.sv
hdl/bignum_io.sv
bench/tb_clock.sv
bench/bignum_io_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f flist.f --top-module bignum_io_tb -o bignum_io_sim

output=$(./obj_dir/bignum_io_sim || true)
echo "$output"

if echo "$output" | grep -q "All checks passed"; then
    exit 0
else
    exit 1
fi

// ==== bench/bignum_io_tb.sv ====
`timescale 1ns/1ps

module bignum_io_tb;
    import bignum_pkg::*;

    typedef enum logic [1:0] {act_write, act_wait, act_read} action_t;
    typedef enum logic {src_model, src_zero} source_t;

    typedef struct packed {
        action_t    act;
        view_t      view;
        logic [5:0] pos;
        word_t      value;
        source_t    src;
    } entry_t;

    logic        clk;
    logic        resetn;
    logic        input_valid;
    word_t       input_value;
    word_index_t input_sel;
    view_t       input_which;
    slot_t       display_number;
    logic        display_valid;
    label_t      display_name;
    word_t       display_value;
    logic        product_valid;

    entry_t   table_q[$];
    operand_t model_a;
    operand_t model_b;
    product_t model_product;
    int       cycle_count = 0;
    int       cycle_limit = 0;

    tb_clock tb_clock_i (.clk(clk));

    bignum_io bignum_io_i (
        .clk            (clk),
        .resetn         (resetn),
        .input_valid    (input_valid),
        .input_value    (input_value),
        .input_sel      (input_sel),
        .input_which    (input_which),
        .display_number (display_number),
        .display_valid  (display_valid),
        .display_name   (display_name),
        .display_value  (display_value),
        .product_valid  (product_valid)
    );

    // ********************
    // table building
    // ********************

    function automatic void add_write(view_t view, logic [5:0] idx, word_t value);
        table_q.push_back('{act_write, view, idx, value, src_model});
    endfunction

    function automatic void add_wait();
        table_q.push_back('{act_wait, view_in1, 6'd0, 32'h0, src_model});
    endfunction

    function automatic void add_read(view_t view, logic [5:0] slot, source_t src);
        table_q.push_back('{act_read, view, slot, 32'h0, src});
    endfunction

    function automatic void build_table();
        // empty operands right after reset
        add_read(view_in1, 6'd1, src_zero);
        add_read(view_in2, 6'd1, src_zero);
        // a few words per operand with all ones near the top for long carries
        add_write(view_in1, 6'd0, 32'h1234_5678);
        add_write(view_in1, 6'd5, $urandom());
        add_write(view_in1, 6'd31, $urandom());
        add_write(view_in2, 6'd0, $urandom());
        add_write(view_in2, 6'd2, 32'hffff_ffff);
        add_write(view_in2, 6'd31, 32'hffff_ffff);
        add_read(view_in1, 6'd1, src_model);
        add_read(view_in1, 6'd6, src_model);
        add_read(view_in1, 6'd32, src_model);
        add_read(view_in1, 6'd2, src_zero);
        add_read(view_in2, 6'd3, src_model);
        add_read(view_in2, 6'd32, src_model);
        add_read(view_in2, 6'd33, src_zero);
        add_wait();
        for (int s = 1; s <= display_slots; s++)
            add_read(view_out, 6'(s), src_model);
        // second write lands after the run has summed pair (0, 0)
        add_write(view_in1, 6'd1, $urandom());
        add_write(view_in2, 6'd0, $urandom());
        add_write(2'd3, 6'd4, $urandom());
        add_wait();
        add_read(view_in1, 6'd2, src_model);
        add_read(view_in2, 6'd1, src_model);
        add_read(view_in1, 6'd5, src_zero);
        for (int s = 1; s <= display_slots; s++)
            add_read(view_out, 6'(s), src_model);
        // out of range slots and the unused view
        add_read(view_in1, 6'd0, src_model);
        add_read(view_out, 6'd45, src_model);
        add_read(2'd3, 6'd1, src_model);
        add_read(view_in2, 6'd63, src_model);
    endfunction

    // ********************
    // checking
    // ********************

    task automatic check_value(string name, logic [63:0] got, logic [63:0] exp);
        assert (got === exp)
        else
        begin
            $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
            $display("Checks failed");
            $fatal(1);
        end
    endtask

    // view word with operands zero extended to product width
    function automatic word_t view_word(view_t view, logic [5:0] slot);
        product_t wide;
        case (view)
            2'd0:    wide = product_t'(model_a);
            2'd1:    wide = product_t'(model_b);
            2'd2:    wide = model_product;
            default: wide = '0;
        endcase
        return wide[word_w*(int'(slot) - 1) +: word_w];
    endfunction

    function automatic label_t view_label(view_t view);
        case (view)
            2'd0:    return "IN1";
            2'd1:    return "IN2";
            2'd2:    return "OUT";
            default: return '0;
        endcase
    endfunction

    task automatic do_write(view_t view, logic [5:0] idx, word_t value);
        @(posedge clk);
        input_valid <= 1'b1;
        input_which <= view;
        input_sel   <= idx[4:0];
        input_value <= value;
        @(posedge clk);
        input_valid <= 1'b0;
        if (view == 2'd0)
            model_a[word_w*idx +: word_w] = value;
        else if (view == 2'd1)
            model_b[word_w*idx +: word_w] = value;
        model_product = product_t'(model_a) * product_t'(model_b);
        // accepted writes restart the multiplier
        if (view == 2'd0 || view == 2'd1)
        begin
            @(posedge clk);
            @(negedge clk);
            check_value("product_valid", 64'(product_valid), 64'(0));
        end
    endtask

    task automatic wait_product();
        do
        begin
            @(negedge clk);
        end
        while (!product_valid);
    endtask

    task automatic do_read(view_t view, logic [5:0] slot, source_t src);
        logic   exp_valid;
        label_t exp_name;
        word_t  exp_value;
        @(posedge clk);
        input_which    <= view;
        display_number <= slot;
        // view register then reply register
        repeat (2) @(posedge clk);
        @(negedge clk);
        exp_valid = (slot >= 6'd1) && (slot <= 6'(display_slots));
        exp_name  = exp_valid ? view_label(view) : '0;
        exp_value = '0;
        if (exp_valid && src == src_model)
            exp_value = view_word(view, slot);
        check_value("display_valid", 64'(display_valid), 64'(exp_valid));
        check_value("display_name", 64'(display_name), 64'(exp_name));
        check_value("display_value", 64'(display_value), 64'(exp_value));
    endtask

    // ********************
    // watchdog
    // ********************

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit != 0 && cycle_count >= cycle_limit)
        begin
            $display("timeout: no result within %0d cycles", cycle_limit);
            $display("Checks failed");
            $fatal(1);
        end
    end

    initial
    begin
        int waits;
        void'($urandom(32'h181a));
        resetn         <= 1'b0;
        input_valid    <= 1'b0;
        input_value    <= '0;
        input_sel      <= '0;
        input_which    <= view_in1;
        display_number <= '0;
        model_a        = '0;
        model_b        = '0;
        model_product  = '0;
        build_table();
        waits = 0;
        foreach (table_q[k])
            if (table_q[k].act == act_wait)
                waits++;
        cycle_limit = 16 + 3 * 1026 * waits + 10 * table_q.size();

        repeat (16) @(posedge clk);
        resetn <= 1'b1;
        @(negedge clk);
        check_value("display_valid", 64'(display_valid), 64'(0));
        check_value("product_valid", 64'(product_valid), 64'(0));

        foreach (table_q[k])
        begin
            case (table_q[k].act)
                act_write: do_write(table_q[k].view, table_q[k].pos, table_q[k].value);
                act_wait:  wait_product();
                act_read:  do_read(table_q[k].view, table_q[k].pos, table_q[k].src);
                default:   ;
            endcase
        end

        $display("All checks passed");
        $finish;
    end

endmodule

// ==== bench/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
    output logic clk
);

    // 8 ns period
    initial
    begin
        clk = 1'b0;
    end

    always
    begin
        #4 clk = ~clk;
    end

endmodule

// ==== hdl/bignum_io.sv ====
`timescale 1ns/1ps

module bignum_io (
    input  logic                    clk,
    input  logic                    resetn,
    input  logic                    input_valid,
    input  bignum_pkg::word_t       input_value,
    input  bignum_pkg::word_index_t input_sel,
    input  bignum_pkg::view_t       input_which,
    input  bignum_pkg::slot_t       display_number,
    output logic                    display_valid,
    output bignum_pkg::label_t      display_name,
    output bignum_pkg::word_t       display_value,
    output logic                    product_valid
);
    import bignum_pkg::*;

    operand_t operand_a;
    operand_t operand_b;
    logic     operands_changed;
    product_t product;

    // ********************
    // operand entry
    // ********************

    operand_bank operand_bank_i (
        .clk              (clk),
        .resetn           (resetn),
        .input_valid      (input_valid),
        .input_value      (input_value),
        .input_sel        (input_sel),
        .input_which      (input_which),
        .operand_a        (operand_a),
        .operand_b        (operand_b),
        .operands_changed (operands_changed)
    );

    // ********************
    // multiply
    // ********************

    // any write restarts the product
    bignum_multiplier bignum_multiplier_i (
        .clk           (clk),
        .resetn        (resetn),
        .start         (operands_changed),
        .operand_a     (operand_a),
        .operand_b     (operand_b),
        .product       (product),
        .product_valid (product_valid)
    );

    // ********************
    // display
    // ********************

    display_readout display_readout_i (
        .clk            (clk),
        .resetn         (resetn),
        .input_which    (input_which),
        .display_number (display_number),
        .operand_a      (operand_a),
        .operand_b      (operand_b),
        .product        (product),
        .display_valid  (display_valid),
        .display_name   (display_name),
        .display_value  (display_value)
    );

endmodule

// ==== hdl/display_readout.sv ====
`timescale 1ns/1ps

module display_readout (
    input  logic                 clk,
    input  logic                 resetn,
    input  bignum_pkg::view_t    input_which,
    input  bignum_pkg::slot_t    display_number,
    input  bignum_pkg::operand_t operand_a,
    input  bignum_pkg::operand_t operand_b,
    input  bignum_pkg::product_t product,
    output logic                 display_valid,
    output bignum_pkg::label_t   display_name,
    output bignum_pkg::word_t    display_value
);
    import bignum_pkg::*;

    product_t view_sel;
    label_t   label_sel;
    product_t view_data;
    label_t   view_label;
    slot_t    word_sel;
    logic     slot_ok;

    // ********************
    // view select
    // ********************

    always_comb
    begin
        case (input_which)
            view_in1:
            begin
                view_sel  = product_t'(operand_a);
                label_sel = label_in1;
            end
            view_in2:
            begin
                view_sel  = product_t'(operand_b);
                label_sel = label_in2;
            end
            view_out:
            begin
                view_sel  = product;
                label_sel = label_out;
            end
            default:
            begin
                // unused view code, blank
                view_sel  = '0;
                label_sel = '0;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        view_data  <= view_sel;
        view_label <= label_sel;
    end

    // ********************
    // slot reply
    // ********************

    // slots count from 1
    assign word_sel = display_number - slot_t'(1);
    assign slot_ok  = (display_number != '0) && (display_number <= slot_t'(display_slots));

    always_ff @(posedge clk)
    begin
        if (!resetn)
        begin
            display_valid <= 1'b0;
            display_name  <= '0;
            display_value <= '0;
        end
        else if (slot_ok)
        begin
            display_valid <= 1'b1;
            display_name  <= view_label;
            display_value <= view_data[word_w*word_sel +: word_w];
        end
        else
        begin
            display_valid <= 1'b0;
            display_name  <= '0;
            display_value <= '0;
        end
    end

endmodule

// ==== hdl/bignum_multiplier.sv ====
`timescale 1ns/1ps

module bignum_multiplier (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 start,
    input  bignum_pkg::operand_t operand_a,
    input  bignum_pkg::operand_t operand_b,
    output bignum_pkg::product_t product,
    output logic                 product_valid
);
    import bignum_pkg::*;

    mult_state_t state;
    word_index_t idx_a;
    word_index_t idx_b;
    product_t    acc;

    word_t               word_a;
    word_t               word_b;
    logic [2*word_w-1:0] partial;
    logic [5:0]          shift_words;
    product_t            partial_wide;
    product_t            acc_next;
    logic                idx_b_last;
    logic                last_step;

    // ********************
    // datapath
    // ********************

    // current word pair
    assign word_a = operand_a[word_w*idx_a +: word_w];
    assign word_b = operand_b[word_w*idx_b +: word_w];

    // 32x32 partial product, full 64 bits kept
    assign partial = word_a * word_b;

    // weight of the pair is 2^(32*(i+j))
    assign shift_words  = {1'b0, idx_a} + {1'b0, idx_b};
    assign partial_wide = product_t'(partial) << (word_w * shift_words);

    // full width add so the carry ripples into every higher word
    assign acc_next = acc + partial_wide;

    assign idx_b_last = (idx_b == word_index_t'(operand_words - 1));
    assign last_step  = idx_b_last && (idx_a == word_index_t'(operand_words - 1));

    // ********************
    // control
    // ********************

    always_ff @(posedge clk)
    begin
        if (!resetn)
        begin
            state <= mult_idle;
            idx_a <= '0;
            idx_b <= '0;
        end
        else if (start)
        begin
            // restart from word pair (0, 0), also mid run
            state <= mult_run;
            idx_a <= '0;
            idx_b <= '0;
        end
        else
        begin
            case (state)
                mult_idle:
                begin
                    idx_a <= '0;
                    idx_b <= '0;
                end
                mult_run:
                begin
                    // inner loop over operand_b words
                    idx_b <= idx_b + 1'b1;
                    if (idx_b_last)
                    begin
                        idx_a <= idx_a + 1'b1;
                    end
                    if (last_step)
                    begin
                        state <= mult_idle;
                    end
                end
                default:
                begin
                    state <= mult_idle;
                end
            endcase
        end
    end

    // accumulator
    always_ff @(posedge clk)
    begin
        if (start)
        begin
            acc <= '0;
        end
        else if (state == mult_run)
        begin
            acc <= acc_next;
        end
    end

    // ********************
    // result
    // ********************

    always_ff @(posedge clk)
    begin
        if (!resetn)
        begin
            product       <= '0;
            product_valid <= 1'b0;
        end
        else if (start)
        begin
            product_valid <= 1'b0;
        end
        else if ((state == mult_run) && last_step)
        begin
            // take the sum including the final pair
            product       <= acc_next;
            product_valid <= 1'b1;
        end
    end

endmodule

// ==== hdl/operand_bank.sv ====
`timescale 1ns/1ps

module operand_bank (
    input  logic                    clk,
    input  logic                    resetn,
    input  logic                    input_valid,
    input  bignum_pkg::word_t       input_value,
    input  bignum_pkg::word_index_t input_sel,
    input  bignum_pkg::view_t       input_which,
    output bignum_pkg::operand_t    operand_a,
    output bignum_pkg::operand_t    operand_b,
    output logic                    operands_changed
);
    import bignum_pkg::*;

    logic write_a;
    logic write_b;

    // only the two operand views accept words
    assign write_a = input_valid && (input_which == view_in1);
    assign write_b = input_valid && (input_which == view_in2);

    always_ff @(posedge clk)
    begin
        if (!resetn)
        begin
            operand_a        <= '0;
            operand_b        <= '0;
            operands_changed <= 1'b0;
        end
        else
        begin
            // one cycle pulse, restarts the multiplier
            operands_changed <= write_a || write_b;

            if (write_a)
            begin
                operand_a[word_w*input_sel +: word_w] <= input_value;
            end

            if (write_b)
            begin
                operand_b[word_w*input_sel +: word_w] <= input_value;
            end
        end
    end

endmodule

// ==== hdl/bignum_pkg.sv ====
package bignum_pkg;

    // ********************
    // widths
    // ********************
    localparam int word_w        = 32;
    localparam int operand_w     = 1024;
    localparam int product_w     = 2048;
    localparam int operand_words = operand_w / word_w;
    localparam int display_slots = 44;

    typedef logic [word_w-1:0]    word_t;
    typedef logic [operand_w-1:0] operand_t;
    typedef logic [product_w-1:0] product_t;
    typedef logic [4:0]           word_index_t;
    typedef logic [5:0]           slot_t;
    typedef logic [39:0]          label_t;
    typedef logic [1:0]           view_t;

    // ********************
    // views and labels
    // ********************
    localparam view_t view_in1 = 2'd0;
    localparam view_t view_in2 = 2'd1;
    localparam view_t view_out = 2'd2;

    // three ascii chars, upper bytes stay zero
    localparam label_t label_in1 = "IN1";
    localparam label_t label_in2 = "IN2";
    localparam label_t label_out = "OUT";

    // multiplier control
    typedef enum logic {
        mult_idle,
        mult_run
    } mult_state_t;

endpackage
